/* verilog/mem_sys_pkg.sv */
package mem_sys_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int data_w         = 64;
  localparam int strb_w         = data_w / 8;
  localparam int line_addr_bits = $clog2(strb_w);
  localparam int dmem_bytes     = 2048;
  localparam int dmem_addr_w    = $clog2(dmem_bytes);
  localparam int imem_bytes     = 1024;
  localparam int imem_addr_w    = $clog2(imem_bytes);
  // top bit picks imem (1) or dmem (0)
  localparam int addr_w         = dmem_addr_w + 1;
  localparam int bank_lines     = 128;
  localparam int bank_line_w    = $clog2(bank_lines);
  localparam int imem_line_w    = imem_addr_w - line_addr_bits;

  typedef logic [data_w-1:0]      data_t;
  typedef logic [strb_w-1:0]      strb_t;
  typedef logic [dmem_addr_w-1:0] dmem_addr_t;
  typedef logic [bank_line_w-1:0] bank_line_t;
  typedef logic [imem_line_w-1:0] imem_line_t;

  ////////////////////
  // dma address views
  ////////////////////
  typedef struct packed {
    logic                      region;
    bank_line_t                line;
    logic                      bank;
    logic [line_addr_bits-1:0] offset;
  } dma_dmem_view_t;

  typedef struct packed {
    logic                                         region;
    logic [addr_w-imem_line_w-line_addr_bits-2:0] unused;
    imem_line_t                                   line;
    logic [line_addr_bits-1:0]                    offset;
  } dma_imem_view_t;

  typedef union packed {
    dma_dmem_view_t dmem;
    dma_imem_view_t imem;
  } dma_addr_u;

  typedef struct packed {
    dma_addr_u addr;
    strb_t     strb;
    data_t     data;
  } dma_wr_cmd_t;

  // one request on a bank port, wen of zero means read
  typedef struct packed {
    logic       en;
    strb_t      wen;
    bank_line_t line;
    data_t      data;
  } bank_req_t;

  typedef struct packed {
    logic       en;
    strb_t      wen;
    dmem_addr_t addr;
    data_t      wr_data;
  } core_dmem_req_t;

endpackage

/* verilog/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_ready
);

  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  // head comes straight from the storage flops, so no input reaches the output
  assign in_ready  = !count[DEPTH_LOG2];
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + DEPTH_LOG2'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + DEPTH_LOG2'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + (DEPTH_LOG2+1)'(1);
        2'b01:   count <= count - (DEPTH_LOG2+1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/dma_req_split.sv */
`timescale 1ns/1ps

module dma_req_split (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  mem_sys_pkg::dma_wr_cmd_t wr_cmd,
  output logic                     wr_ready,
  input  logic                     rd_en,
  input  mem_sys_pkg::dma_addr_u   rd_addr,
  output logic                     rd_ready,
  input  logic                     resp_ready,
  output mem_sys_pkg::strb_t       imem_we,
  output mem_sys_pkg::imem_line_t  imem_line,
  output mem_sys_pkg::data_t       imem_data,
  output logic                     dwr_valid,
  output mem_sys_pkg::dma_wr_cmd_t dwr_cmd,
  input  logic                     wr_pop,
  output logic                     drd_valid,
  output mem_sys_pkg::dmem_addr_t  drd_addr,
  input  logic                     rd_pop
);

  logic               imem_push;
  logic               imem_room;
  logic               imem_valid;
  mem_sys_pkg::strb_t imem_strb;
  logic               dwr_push;
  logic               dwr_room;
  logic               drd_push;
  logic               drd_room;

  ////////////////////
  // command decode
  ////////////////////
  assign wr_ready  = imem_room && dwr_room;
  // no read is taken while the response side is stalled
  assign rd_ready  = drd_room && resp_ready;
  assign imem_push = wr_en && wr_ready && wr_cmd.addr.imem.region;
  assign dwr_push  = wr_en && wr_ready && !wr_cmd.addr.dmem.region;
  // imem reads are not served, they are accepted and dropped here
  assign drd_push  = rd_en && rd_ready && !rd_addr.dmem.region;

  req_fifo #(
    .WIDTH(mem_sys_pkg::imem_line_w + mem_sys_pkg::strb_w + mem_sys_pkg::data_w),
    .DEPTH_LOG2(2)
  ) imem_wr_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (imem_push),
    .in_data  ({wr_cmd.addr.imem.line, wr_cmd.strb, wr_cmd.data}),
    .in_ready (imem_room),
    .out_valid(imem_valid),
    .out_data ({imem_line, imem_strb, imem_data}),
    .out_ready(1'b1)
  );

  // imem write port has no contention
  assign imem_we = imem_strb & {mem_sys_pkg::strb_w{imem_valid}};

  req_fifo #(
    .WIDTH($bits(mem_sys_pkg::dma_wr_cmd_t)),
    .DEPTH_LOG2(2)
  ) dmem_wr_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (dwr_push),
    .in_data  (wr_cmd),
    .in_ready (dwr_room),
    .out_valid(dwr_valid),
    .out_data (dwr_cmd),
    .out_ready(wr_pop)
  );

  req_fifo #(
    .WIDTH(mem_sys_pkg::dmem_addr_w),
    .DEPTH_LOG2(2)
  ) dmem_rd_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (drd_push),
    .in_data  ({rd_addr.dmem.line, rd_addr.dmem.bank, rd_addr.dmem.offset}),
    .in_ready (drd_room),
    .out_valid(drd_valid),
    .out_data (drd_addr),
    .out_ready(rd_pop)
  );

endmodule

/* verilog/dmem_port_arbiter.sv */
`timescale 1ns/1ps

module dmem_port_arbiter (
  input  logic                     dwr_valid,
  input  mem_sys_pkg::dma_wr_cmd_t dwr_cmd,
  input  logic                     drd_valid,
  input  mem_sys_pkg::dmem_addr_t  drd_addr,
  output logic                     wr_pop,
  output logic                     rd_pop,
  output logic                     rd_grant,
  output logic                     rd_bank,
  output mem_sys_pkg::bank_req_t   a_req [2]
);

  mem_sys_pkg::dma_addr_u rd_view;
  logic [1:0]             wr_hit;
  logic [1:0]             rd_hit;

  // read head seen through the same dmem view as the write head
  assign rd_view = {1'b0, drd_addr};

  // per bank the write wins, the read waits for a free cycle
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      wr_hit[b] = dwr_valid && (dwr_cmd.addr.dmem.bank == 1'(b));
      rd_hit[b] = drd_valid && (rd_view.dmem.bank == 1'(b)) && !wr_hit[b];
      a_req[b].en   = wr_hit[b] || rd_hit[b];
      a_req[b].wen  = wr_hit[b] ? dwr_cmd.strb : '0;
      a_req[b].line = wr_hit[b] ? dwr_cmd.addr.dmem.line : rd_view.dmem.line;
      a_req[b].data = dwr_cmd.data;
    end
  end

  assign wr_pop   = |wr_hit;
  assign rd_pop   = |rd_hit;
  assign rd_grant = |rd_hit;
  // only one read head, so at most one bank is granted
  assign rd_bank  = rd_hit[1];

endmodule

/* verilog/dual_port_bank.sv */
`timescale 1ns/1ps

module dual_port_bank (
  input  logic                   clk,
  input  mem_sys_pkg::bank_req_t a_req,
  input  mem_sys_pkg::bank_req_t b_req,
  output mem_sys_pkg::data_t     a_rd_data,
  output mem_sys_pkg::data_t     b_rd_data
);

  mem_sys_pkg::data_t mem [mem_sys_pkg::bank_lines];

  ////////////////////
  // byte writes
  ////////////////////
  // port b lands last, so it wins a same-byte collision
  always_ff @(posedge clk) begin
    for (int i = 0; i < mem_sys_pkg::strb_w; i++) begin
      if (a_req.en && a_req.wen[i]) begin
        mem[a_req.line][i*8 +: 8] <= a_req.data[i*8 +: 8];
      end
      if (b_req.en && b_req.wen[i]) begin
        mem[b_req.line][i*8 +: 8] <= b_req.data[i*8 +: 8];
      end
    end
  end

  ////////////////////
  // reads
  ////////////////////
  // read data holds until the next read on that port
  always_ff @(posedge clk) begin
    if (a_req.en && (a_req.wen == '0)) begin
      a_rd_data <= mem[a_req.line];
    end
  end

  always_ff @(posedge clk) begin
    if (b_req.en && (b_req.wen == '0)) begin
      b_rd_data <= mem[b_req.line];
    end
  end

endmodule

/* verilog/instr_ram.sv */
`timescale 1ns/1ps

module instr_ram (
  input  logic                    clk,
  input  mem_sys_pkg::strb_t      we,
  input  mem_sys_pkg::imem_line_t wr_line,
  input  mem_sys_pkg::data_t      wr_data,
  input  logic                    ren,
  input  mem_sys_pkg::imem_line_t rd_line,
  output mem_sys_pkg::data_t      rd_data
);

  mem_sys_pkg::data_t mem [2**mem_sys_pkg::imem_line_w];

  always_ff @(posedge clk) begin
    for (int i = 0; i < mem_sys_pkg::strb_w; i++) begin
      if (we[i]) begin
        mem[wr_line][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
    if (ren) begin
      rd_data <= mem[rd_line];
    end
  end

endmodule

/* verilog/rd_resp_path.sv */
`timescale 1ns/1ps

module rd_resp_path (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_grant,
  input  logic                        rd_bank,
  input  mem_sys_pkg::data_t          a_rd_data [2],
  input  mem_sys_pkg::core_dmem_req_t core_req,
  input  mem_sys_pkg::data_t          b_rd_data [2],
  output mem_sys_pkg::data_t          core_rd_data,
  output logic                        core_rd_valid,
  output logic                        resp_valid,
  output mem_sys_pkg::data_t          resp_data,
  input  logic                        resp_ready
);

  logic grant_q;
  logic bank_q;
  logic core_rd_q;
  logic core_bank_q;

  ////////////////////
  // request tracking
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q   <= 1'b0;
      core_rd_q <= 1'b0;
    end else begin
      grant_q   <= rd_grant;
      core_rd_q <= core_req.en && (core_req.wen == '0);
    end
  end

  always_ff @(posedge clk) begin
    bank_q      <= rd_bank;
    core_bank_q <= core_req.addr[mem_sys_pkg::line_addr_bits];
  end

  // core side, bank data is valid one cycle after the request
  assign core_rd_data  = b_rd_data[core_bank_q];
  assign core_rd_valid = core_rd_q;

  // dma side, never fills since reads stop while resp_ready is low
  req_fifo #(
    .WIDTH(mem_sys_pkg::data_w),
    .DEPTH_LOG2(3)
  ) resp_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (grant_q),
    .in_data  (a_rd_data[bank_q]),
    .in_ready (),
    .out_valid(resp_valid),
    .out_data (resp_data),
    .out_ready(resp_ready)
  );

endmodule

/* verilog/mem_sys.sv */
`timescale 1ns/1ps

module mem_sys (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 dma_cmd_wr_en,
  input  mem_sys_pkg::dma_wr_cmd_t             dma_cmd_wr,
  output logic                                 dma_cmd_wr_ready,
  input  logic                                 dma_cmd_rd_en,
  input  mem_sys_pkg::dma_addr_u               dma_cmd_rd_addr,
  output logic                                 dma_cmd_rd_ready,
  output logic                                 dma_rd_resp_valid,
  output mem_sys_pkg::data_t                   dma_rd_resp_data,
  input  logic                                 dma_rd_resp_ready,
  input  mem_sys_pkg::core_dmem_req_t          core_dmem,
  output mem_sys_pkg::data_t                   core_dmem_rd_data,
  output logic                                 core_dmem_rd_valid,
  input  logic                                 core_imem_ren,
  input  logic [mem_sys_pkg::imem_addr_w-1:0]  core_imem_addr,
  output mem_sys_pkg::data_t                   core_imem_rd_data
);

  logic                     dwr_valid;
  mem_sys_pkg::dma_wr_cmd_t dwr_cmd;
  logic                     wr_pop;
  logic                     drd_valid;
  mem_sys_pkg::dmem_addr_t  drd_addr;
  logic                     rd_pop;
  logic                     rd_grant;
  logic                     rd_bank;
  mem_sys_pkg::strb_t       imem_we;
  mem_sys_pkg::imem_line_t  imem_line;
  mem_sys_pkg::data_t       imem_data;
  mem_sys_pkg::bank_req_t   a_req [2];
  mem_sys_pkg::bank_req_t   b_req [2];
  mem_sys_pkg::data_t       a_rd_data [2];
  mem_sys_pkg::data_t       b_rd_data [2];

  dma_req_split split (
    .clk(clk), .rst(rst),
    .wr_en(dma_cmd_wr_en), .wr_cmd(dma_cmd_wr), .wr_ready(dma_cmd_wr_ready),
    .rd_en(dma_cmd_rd_en), .rd_addr(dma_cmd_rd_addr), .rd_ready(dma_cmd_rd_ready),
    .resp_ready(dma_rd_resp_ready),
    .imem_we(imem_we), .imem_line(imem_line), .imem_data(imem_data),
    .dwr_valid(dwr_valid), .dwr_cmd(dwr_cmd), .wr_pop(wr_pop),
    .drd_valid(drd_valid), .drd_addr(drd_addr), .rd_pop(rd_pop)
  );

  dmem_port_arbiter arb (
    .dwr_valid(dwr_valid), .dwr_cmd(dwr_cmd), .drd_valid(drd_valid), .drd_addr(drd_addr),
    .wr_pop(wr_pop), .rd_pop(rd_pop), .rd_grant(rd_grant), .rd_bank(rd_bank), .a_req(a_req)
  );

  ////////////////////
  // dmem banks
  ////////////////////
  // port b of each bank belongs to the core
  for (genvar b = 0; b < 2; b++) begin : g_bank
    assign b_req[b] = '{
      en:   core_dmem.en && (core_dmem.addr[mem_sys_pkg::line_addr_bits] == 1'(b)),
      wen:  core_dmem.wen,
      line: core_dmem.addr[mem_sys_pkg::dmem_addr_w-1:mem_sys_pkg::line_addr_bits+1],
      data: core_dmem.wr_data
    };

    dual_port_bank bank (
      .clk(clk), .a_req(a_req[b]), .b_req(b_req[b]),
      .a_rd_data(a_rd_data[b]), .b_rd_data(b_rd_data[b])
    );
  end

  instr_ram imem (
    .clk(clk), .we(imem_we), .wr_line(imem_line), .wr_data(imem_data),
    .ren(core_imem_ren),
    .rd_line(core_imem_addr[mem_sys_pkg::imem_addr_w-1:mem_sys_pkg::line_addr_bits]),
    .rd_data(core_imem_rd_data)
  );

  rd_resp_path resp (
    .clk(clk), .rst(rst), .rd_grant(rd_grant), .rd_bank(rd_bank),
    .a_rd_data(a_rd_data), .core_req(core_dmem), .b_rd_data(b_rd_data),
    .core_rd_data(core_dmem_rd_data), .core_rd_valid(core_dmem_rd_valid),
    .resp_valid(dma_rd_resp_valid), .resp_data(dma_rd_resp_data),
    .resp_ready(dma_rd_resp_ready)
  );

endmodule

/* tests/mem_sys_tb.sv */
`timescale 1ns/1ps

module mem_sys_tb;

  logic                                clk;
  logic                                rst;
  logic                                dma_cmd_wr_en;
  mem_sys_pkg::dma_wr_cmd_t            dma_cmd_wr;
  logic                                dma_cmd_wr_ready;
  logic                                dma_cmd_rd_en;
  mem_sys_pkg::dma_addr_u              dma_cmd_rd_addr;
  logic                                dma_cmd_rd_ready;
  logic                                dma_rd_resp_valid;
  mem_sys_pkg::data_t                  dma_rd_resp_data;
  logic                                dma_rd_resp_ready;
  mem_sys_pkg::core_dmem_req_t         core_dmem;
  mem_sys_pkg::data_t                  core_dmem_rd_data;
  logic                                core_dmem_rd_valid;
  logic                                core_imem_ren;
  logic [mem_sys_pkg::imem_addr_w-1:0] core_imem_addr;
  mem_sys_pkg::data_t                  core_imem_rd_data;

  // model state, one entry per line
  mem_sys_pkg::data_t dmem_model [mem_sys_pkg::dmem_bytes / mem_sys_pkg::strb_w];
  mem_sys_pkg::data_t imem_model [mem_sys_pkg::imem_bytes / mem_sys_pkg::strb_w];
  mem_sys_pkg::data_t exp_q [$];
  logic [7:0]         dmem_used [$];
  string              test_name;
  logic               rand_ready;
  logic               resp_held;
  mem_sys_pkg::data_t resp_held_data;
  mem_sys_pkg::data_t resp_exp;

  mem_sys uut (
    .clk(clk), .rst(rst),
    .dma_cmd_wr_en(dma_cmd_wr_en), .dma_cmd_wr(dma_cmd_wr), .dma_cmd_wr_ready(dma_cmd_wr_ready),
    .dma_cmd_rd_en(dma_cmd_rd_en), .dma_cmd_rd_addr(dma_cmd_rd_addr),
    .dma_cmd_rd_ready(dma_cmd_rd_ready),
    .dma_rd_resp_valid(dma_rd_resp_valid), .dma_rd_resp_data(dma_rd_resp_data),
    .dma_rd_resp_ready(dma_rd_resp_ready),
    .core_dmem(core_dmem), .core_dmem_rd_data(core_dmem_rd_data),
    .core_dmem_rd_valid(core_dmem_rd_valid),
    .core_imem_ren(core_imem_ren), .core_imem_addr(core_imem_addr),
    .core_imem_rd_data(core_imem_rd_data)
  );

  always #10 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////
  function automatic mem_sys_pkg::data_t merge_line(input mem_sys_pkg::data_t old_line,
      input mem_sys_pkg::data_t new_line, input mem_sys_pkg::strb_t strb);
    mem_sys_pkg::data_t result;
    result = old_line;
    for (int i = 0; i < mem_sys_pkg::strb_w; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_line[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // line index is {line, bank}, byte offset is random and ignored
  function automatic mem_sys_pkg::dma_addr_u dmem_line_addr(input logic [7:0] idx);
    return {1'b0, idx, 3'($urandom)};
  endfunction

  function automatic mem_sys_pkg::dma_addr_u imem_line_addr(input mem_sys_pkg::imem_line_t line);
    return {1'b1, 1'b0, line, 3'($urandom)};
  endfunction

  ////////////////////
  // checks
  ////////////////////
  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string label, input mem_sys_pkg::data_t expected,
      input mem_sys_pkg::data_t actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("Error in %s (%s): expected %h, actual %h",
                                test_name, label, expected, actual));
    end
  endtask

  task automatic check_flag(input string label, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("Error in %s (%s): expected %b, actual %b",
                                test_name, label, expected, actual));
    end
  endtask

  // a read command is refused while the response side is stalled
  task automatic check_read_refused();
    if (!dma_rd_resp_ready) begin
      check_flag("read ready while stalled", 1'b0, dma_cmd_rd_ready);
    end
  endtask

  // every accepted response is matched against the head of the queue
  always @(posedge clk) begin
    if (rst) begin
      resp_held = 1'b0;
    end else if (dma_rd_resp_valid) begin
      if (resp_held) begin
        check_data("held response", resp_held_data, dma_rd_resp_data);
      end
      if (dma_rd_resp_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_error("A DMA read response arrived with no read outstanding");
        end else begin
          resp_exp = exp_q.pop_front();
          check_data("DMA read response", resp_exp, dma_rd_resp_data);
          resp_held = 1'b0;
        end
      end else begin
        resp_held      = 1'b1;
        resp_held_data = dma_rd_resp_data;
      end
    end else if (resp_held) begin
      stop_with_error("A waiting DMA read response was withdrawn before it was taken");
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  task automatic tick();
    @(negedge clk);
    if (rand_ready) begin
      dma_rd_resp_ready = ($urandom % 3) != 0;
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) tick();
  endtask

  task automatic dma_write(input mem_sys_pkg::dma_addr_u addr, input mem_sys_pkg::strb_t strb,
      input mem_sys_pkg::data_t data);
    int waited;
    waited          = 0;
    dma_cmd_wr_en   = 1'b1;
    dma_cmd_wr.addr = addr;
    dma_cmd_wr.strb = strb;
    dma_cmd_wr.data = data;
    #1;
    while (!dma_cmd_wr_ready) begin
      tick();
      #1;
      waited++;
      if (waited > 100) begin
        stop_with_error("A DMA write command was never accepted");
      end
    end
    if (addr.imem.region) begin
      imem_model[addr.imem.line] = merge_line(imem_model[addr.imem.line], data, strb);
    end else begin
      dmem_model[{addr.dmem.line, addr.dmem.bank}] =
        merge_line(dmem_model[{addr.dmem.line, addr.dmem.bank}], data, strb);
    end
    tick();
    dma_cmd_wr_en = 1'b0;
  endtask

  task automatic dma_read(input logic [7:0] idx);
    int waited;
    waited          = 0;
    dma_cmd_rd_en   = 1'b1;
    dma_cmd_rd_addr = dmem_line_addr(idx);
    #1;
    check_read_refused();
    while (!dma_cmd_rd_ready) begin
      tick();
      #1;
      check_read_refused();
      waited++;
      if (waited > 200) begin
        stop_with_error("A DMA read command was never accepted");
      end
    end
    exp_q.push_back(dmem_model[idx]);
    tick();
    dma_cmd_rd_en = 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      tick();
      waited++;
      if (waited > 400) begin
        stop_with_error("DMA read responses stopped arriving");
      end
    end
  endtask

  task automatic core_write(input logic [7:0] idx, input mem_sys_pkg::strb_t wen,
      input mem_sys_pkg::data_t data);
    core_dmem.en      = 1'b1;
    core_dmem.wen     = wen;
    core_dmem.addr    = {idx, 3'($urandom)};
    core_dmem.wr_data = data;
    dmem_model[idx]   = merge_line(dmem_model[idx], data, wen);
    tick();
    core_dmem.en  = 1'b0;
    core_dmem.wen = '0;
  endtask

  // valid must be high for exactly the one cycle after the request
  task automatic core_read(input logic [7:0] idx);
    mem_sys_pkg::data_t expected;
    expected = dmem_model[idx];
    check_flag("core valid before read", 1'b0, core_dmem_rd_valid);
    core_dmem.en   = 1'b1;
    core_dmem.wen  = '0;
    core_dmem.addr = {idx, 3'($urandom)};
    tick();
    core_dmem.en = 1'b0;
    check_flag("core read valid", 1'b1, core_dmem_rd_valid);
    check_data("core read data", expected, core_dmem_rd_data);
    tick();
    check_flag("core valid after read", 1'b0, core_dmem_rd_valid);
  endtask

  task automatic imem_read(input mem_sys_pkg::imem_line_t line);
    core_imem_ren  = 1'b1;
    core_imem_addr = {line, 3'($urandom)};
    tick();
    core_imem_ren = 1'b0;
    check_data("imem read data", imem_model[line], core_imem_rd_data);
  endtask

  initial begin
    mem_sys_pkg::imem_line_t ilines [$];
    void'($urandom(32'hd14b));
    clk               = 1'b0;
    rst               = 1'b1;
    dma_cmd_wr_en     = 1'b0;
    dma_cmd_wr        = '0;
    dma_cmd_rd_en     = 1'b0;
    dma_cmd_rd_addr   = '0;
    dma_rd_resp_ready = 1'b1;
    core_dmem         = '0;
    core_imem_ren     = 1'b0;
    core_imem_addr    = '0;
    rand_ready        = 1'b0;
    test_name         = "reset";
    idle(8);
    rst = 1'b0;
    tick();
    check_flag("resp valid", 1'b0, dma_rd_resp_valid);
    check_flag("core valid", 1'b0, core_dmem_rd_valid);
    check_flag("write ready", 1'b1, dma_cmd_wr_ready);

    // full lines first so that every line read later is known
    test_name = "dma write then read";
    for (int i = 0; i < 16; i++) begin
      dmem_used.push_back({7'($urandom), 1'(i)});
      dma_write(dmem_line_addr(dmem_used[i]), 8'hff, {$urandom, $urandom});
    end
    for (int i = 0; i < 32; i++) begin
      dma_write(dmem_line_addr(dmem_used[$urandom_range(0, 15)]),
                8'($urandom_range(1, 255)), {$urandom, $urandom});
    end
    idle(8);
    foreach (dmem_used[i]) dma_read(dmem_used[i]);
    wait_responses();

    test_name = "core dmem access";
    for (int i = 0; i < 24; i++) begin
      core_write(dmem_used[$urandom_range(0, 15)], 8'($urandom_range(1, 255)),
                 {$urandom, $urandom});
    end
    foreach (dmem_used[i]) core_read(dmem_used[i]);
    foreach (dmem_used[i]) dma_read(dmem_used[i]);
    wait_responses();

    test_name = "imem write and read";
    for (int i = 0; i < 12; i++) begin
      ilines.push_back(7'($urandom));
      dma_write(imem_line_addr(ilines[i]), 8'hff, {$urandom, $urandom});
    end
    for (int i = 0; i < 16; i++) begin
      dma_write(imem_line_addr(ilines[$urandom_range(0, 11)]),
                8'($urandom_range(1, 255)), {$urandom, $urandom});
    end
    idle(8);
    foreach (ilines[i]) imem_read(ilines[i]);

    test_name  = "dma reads under back-pressure";
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      dma_read(dmem_used[$urandom_range(0, 15)]);
    end
    wait_responses();
    rand_ready        = 1'b0;
    dma_rd_resp_ready = 1'b1;
    idle(4);

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* project.f */
verilog/mem_sys_pkg.sv
verilog/req_fifo.sv
verilog/dma_req_split.sv
verilog/dmem_port_arbiter.sv
verilog/dual_port_bank.sv
verilog/instr_ram.sv
verilog/rd_resp_path.sv
verilog/mem_sys.sv
tests/mem_sys_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= mem_sys_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
